// File: bench/exu_health_monitor_tb.sv
// Testbench for the execution unit health monitor
// A reference model tracks the expected log two edges behind the inputs and is checked
// every falling edge; directed checks confirm each test's end state
`timescale 1ns/1ns

module exu_health_monitor_tb;
   import exu_mon_pkg::*;

   // Cycle budget summed over the tests in the order they run
   localparam int TEST_CYCLES = 3 + 60 + 20 + 45 + 15 + 310;
   localparam int MARGIN      = 200;
   localparam int COUNT_MAX   = (1 << ERR_COUNT_W) - 1;

   logic                   clk;
   logic                   arst_n;
   logic                   enable;
   logic                   clear;
   logic                   wen1;
   logic                   wen2;
   logic [IRF_WORD_W-1:0]  data1;
   logic [IRF_WORD_W-1:0]  data2;
   logic [REG_ADDR_W-1:0]  rd;
   logic                   restore_request;
   logic                   div_wb_req;
   logic [NUM_SRC-1:0]     err_sticky;
   logic [ERR_COUNT_W-1:0] err_count;
   logic [1:0]             first_src;
   logic [REG_ADDR_W-1:0]  first_rd;
   logic                   first_valid;
   logic                   alarm;

   string test_name;
   int    errors;
   int    checks;

   // Reference model state with the event stage first and the log behind it
   logic                  m_wr_err;
   logic [REG_ADDR_W-1:0] m_wr_rd;
   logic [1:0]            m_stall;
   int                    m_run [2];
   logic [NUM_SRC-1:0]    m_sticky;
   int                    m_count;
   logic [1:0]            m_first_src;
   logic [REG_ADDR_W-1:0] m_first_rd;
   logic                  m_first_valid;

   exu_health_monitor UUT (
      .clk             (clk),
      .arst_n          (arst_n),
      .enable          (enable),
      .clear           (clear),
      .irf_wen1        (wen1),
      .irf_wen2        (wen2),
      .irf_data1       (data1),
      .irf_data2       (data2),
      .irf_rd          (rd),
      .restore_request (restore_request),
      .div_wb_req      (div_wb_req),
      .err_sticky      (err_sticky),
      .err_count       (err_count),
      .first_src       (first_src),
      .first_rd        (first_rd),
      .first_valid     (first_valid),
      .alarm           (alarm)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // Even parity per byte, read through the flat view of the word
   function automatic logic parity_ok(irf_word_u w);
      logic ok;
      ok = 1'b1;
      for (int i = 0; i < IRF_BYTES; i++) begin
         if (w.flat.check[i] != ^w.flat.data[8*i +: 8]) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   // Run length after one more sample, parked at STALL_LIMIT+1
   function automatic int next_run(int run, logic high);
      if (!high) begin
         return 0;
      end
      return (run > STALL_LIMIT) ? STALL_LIMIT + 1 : run + 1;
   endfunction

   function automatic irf_word_u make_good();
      irf_word_u w;
      w.flat.data = {$urandom, $urandom};
      for (int i = 0; i < IRF_BYTES; i++) begin
         w.flat.check[i] = ^w.flat.data[8*i +: 8];
      end
      return w;
   endfunction

   // One random check bit flipped, so exactly one lane fails
   function automatic irf_word_u make_bad();
      irf_word_u w;
      int        lane;
      w    = make_good();
      lane = int'($urandom % IRF_BYTES);
      w.flat.check[lane] = ~w.flat.check[lane];
      return w;
   endfunction

   always @(posedge clk or negedge arst_n) begin : ref_model
      logic [NUM_SRC-1:0] ev;
      if (!arst_n) begin
         m_wr_err      <= 1'b0;
         m_wr_rd       <= '0;
         m_stall       <= 2'b00;
         m_run[0]      <= 0;
         m_run[1]      <= 0;
         m_sticky      <= '0;
         m_count       <= 0;
         m_first_src   <= 2'b00;
         m_first_rd    <= '0;
         m_first_valid <= 1'b0;
      end else begin
         m_wr_err   <= enable && ((wen1 && !parity_ok(irf_word_u'(data1)))
                               || (wen2 && !parity_ok(irf_word_u'(data2))));
         m_wr_rd    <= rd;
         m_stall[0] <= enable && restore_request && (m_run[0] == STALL_LIMIT + 1);
         m_stall[1] <= enable && div_wb_req && (m_run[1] == STALL_LIMIT + 1);
         m_run[0]   <= next_run(m_run[0], enable && restore_request);
         m_run[1]   <= next_run(m_run[1], enable && div_wb_req);
         // Log stage sees the events registered at the previous edge
         ev[SRC_WRITE]   = m_wr_err;
         ev[SRC_RESTORE] = m_stall[0];
         ev[SRC_DIV]     = m_stall[1];
         if (clear) begin
            m_sticky      <= '0;
            m_count       <= 0;
            m_first_src   <= 2'b00;
            m_first_rd    <= '0;
            m_first_valid <= 1'b0;
         end else begin
            m_sticky <= m_sticky | ev;
            if ((|ev) && m_count < COUNT_MAX) begin
               m_count <= m_count + 1;
            end
            if ((|ev) && !m_first_valid) begin
               m_first_valid <= 1'b1;
               m_first_src   <= ev[SRC_WRITE] ? SRC_WRITE
                                : (ev[SRC_RESTORE] ? SRC_RESTORE : SRC_DIV);
               m_first_rd    <= ev[SRC_WRITE] ? m_wr_rd : '0;
            end
         end
      end
   end

   task automatic check_val(string what, int exp, int act);
      checks++;
      assert (exp == act) else begin
         $display("CHECK FAILED %s: %s expected %0d actual %0d", test_name, what, exp, act);
         errors++;
      end
   endtask

   // Outputs have settled half a cycle after the rising edge
   always @(negedge clk) begin
      if (arst_n) begin
         check_val("err_sticky", int'(m_sticky), int'(err_sticky));
         check_val("err_count", m_count, int'(err_count));
         check_val("first_valid", int'(m_first_valid), int'(first_valid));
         check_val("first_src", int'(m_first_src), int'(first_src));
         check_val("first_rd", int'(m_first_rd), int'(first_rd));
         check_val("alarm", int'(|m_sticky), int'(alarm));
      end
   end

   // Each wait ends 2 ns after a rising edge, where inputs are driven
   task automatic cycles(int n);
      repeat (n) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic set_idle();
      wen1            = 1'b0;
      wen2            = 1'b0;
      restore_request = 1'b0;
      div_wb_req      = 1'b0;
      clear           = 1'b0;
   endtask

   task automatic clear_log();
      clear = 1'b1;
      cycles(1);
      clear = 1'b0;
      cycles(2);
   endtask

   initial begin : watchdog
      repeat (TEST_CYCLES + MARGIN) @(posedge clk);
      $display("Timeout: tests still running after %0d cycles", TEST_CYCLES + MARGIN);
      $display(">>> FAIL");
      $finish;
   end

   initial begin
      void'($urandom(88));
      errors   = 0;
      checks   = 0;
      arst_n   = 1'b0;
      enable   = 1'b1;
      data1    = '0;
      data2    = '0;
      rd       = '0;
      set_idle();
      test_name = "reset";
      repeat (3) @(posedge clk);
      #2;
      arst_n = 1'b1;
      check_val("err_sticky", 0, int'(err_sticky));
      check_val("err_count", 0, int'(err_count));
      check_val("first_valid", 0, int'(first_valid));
      check_val("alarm", 0, int'(alarm));

      // Good words and short request bursts must leave the log empty
      test_name = "quiet";
      for (int i = 0; i < 50; i++) begin
         wen1            = 1'($urandom);
         wen2            = 1'($urandom);
         data1           = make_good();
         data2           = make_good();
         rd              = REG_ADDR_W'($urandom);
         restore_request = (i % 5) < 2;
         div_wb_req      = (i % 7) < 3;
         cycles(1);
      end
      set_idle();
      cycles(3);
      check_val("err_count", 0, int'(err_count));
      check_val("first_valid", 0, int'(first_valid));

      test_name = "bad_write";
      wen1  = 1'b1;
      wen2  = 1'b1;
      data1 = make_good();
      data2 = make_bad();
      rd    = 5'd13;
      cycles(1);
      set_idle();
      cycles(2);
      check_val("err_count", 1, int'(err_count));
      check_val("sticky write", 1, int'(err_sticky[SRC_WRITE]));
      check_val("first_src", int'(SRC_WRITE), int'(first_src));
      check_val("first_rd", 13, int'(first_rd));
      check_val("alarm", 1, int'(alarm));
      // Two bad ports in one cycle still count as one event cycle
      wen1  = 1'b1;
      wen2  = 1'b1;
      data1 = make_bad();
      data2 = make_bad();
      cycles(1);
      set_idle();
      cycles(2);
      check_val("err_count", 2, int'(err_count));

      test_name = "stall";
      clear_log();
      restore_request = 1'b1;
      cycles(6);
      set_idle();
      cycles(3);
      check_val("err_count", 0, int'(err_count));
      restore_request = 1'b1;
      cycles(10);
      set_idle();
      cycles(3);
      check_val("err_count", 4, int'(err_count));
      check_val("err_sticky", 2, int'(err_sticky));
      div_wb_req = 1'b1;
      cycles(10);
      set_idle();
      cycles(3);
      check_val("err_count", 8, int'(err_count));
      check_val("err_sticky", 6, int'(err_sticky));

      // Divide stall and bad write land in the same cycle, write takes priority
      test_name = "priority";
      clear_log();
      div_wb_req = 1'b1;
      cycles(6);
      wen1  = 1'b1;
      data1 = make_bad();
      rd    = 5'd7;
      cycles(1);
      set_idle();
      cycles(2);
      check_val("err_count", 1, int'(err_count));
      check_val("first_src", int'(SRC_WRITE), int'(first_src));
      check_val("first_rd", 7, int'(first_rd));
      check_val("err_sticky", 5, int'(err_sticky));

      // Event reaches the log on the same edge that samples clear
      test_name = "clear_wins";
      wen2  = 1'b1;
      data2 = make_bad();
      cycles(1);
      set_idle();
      clear = 1'b1;
      cycles(1);
      clear = 1'b0;
      cycles(2);
      check_val("err_count", 0, int'(err_count));
      check_val("first_valid", 0, int'(first_valid));

      test_name = "disabled";
      enable          = 1'b0;
      wen1            = 1'b1;
      wen2            = 1'b1;
      data1           = make_bad();
      data2           = make_bad();
      restore_request = 1'b1;
      div_wb_req      = 1'b1;
      cycles(12);
      set_idle();
      enable = 1'b1;
      cycles(3);
      check_val("err_count", 0, int'(err_count));
      check_val("alarm", 0, int'(alarm));

      test_name = "saturate";
      restore_request = 1'b1;
      cycles(270);
      check_val("err_count", COUNT_MAX, int'(err_count));
      cycles(5);
      set_idle();
      cycles(3);
      check_val("err_count", COUNT_MAX, int'(err_count));

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

// File: list.f
verilog/exu_mon_pkg.sv
verilog/mon_event_if.sv
verilog/irf_write_checker.sv
verilog/req_stall_watchdog.sv
verilog/monitor_error_log.sv
verilog/exu_health_monitor.sv
bench/exu_health_monitor_tb.sv

// File: run.sh
#!/bin/sh
# Build the health monitor testbench with Verilator, run it, then look for the fail line
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f list.f --top-module exu_health_monitor_tb \
   -o sim_tb > build.log 2>&1 \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q '>>> FAIL' sim.log && exit 1 || exit 0

// File: verilog/exu_health_monitor.sv
// Top level of the execution unit health monitor
// Sits beside the register file write path and the restore and divide requests
// It only observes; the outputs give the sticky error state and alarm
`timescale 1ns/1ns

module exu_health_monitor (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic                                enable,
   input  logic                                clear,
   input  logic                                irf_wen1,
   input  logic                                irf_wen2,
   input  logic [exu_mon_pkg::IRF_WORD_W-1:0]  irf_data1,
   input  logic [exu_mon_pkg::IRF_WORD_W-1:0]  irf_data2,
   input  logic [exu_mon_pkg::REG_ADDR_W-1:0]  irf_rd,
   input  logic                                restore_request,
   input  logic                                div_wb_req,
   output logic [exu_mon_pkg::NUM_SRC-1:0]     err_sticky,
   output logic [exu_mon_pkg::ERR_COUNT_W-1:0] err_count,
   output logic [1:0]                          first_src,
   output logic [exu_mon_pkg::REG_ADDR_W-1:0]  first_rd,
   output logic                                first_valid,
   output logic                                alarm
);
   import exu_mon_pkg::*;

   // Events from both front ends meet here on their way to the log
   mon_event_if ev ();

   // The raw write words are read as lanes inside the checker
   irf_write_checker u_wchk (
      .clk    (clk),
      .arst_n (arst_n),
      .enable (enable),
      .wen1   (irf_wen1),
      .wen2   (irf_wen2),
      .data1  (irf_word_u'(irf_data1)),
      .data2  (irf_word_u'(irf_data2)),
      .rd     (irf_rd),
      .ev     (ev.wchk)
   );

   req_stall_watchdog u_wdog (
      .clk             (clk),
      .arst_n          (arst_n),
      .enable          (enable),
      .restore_request (restore_request),
      .div_wb_req      (div_wb_req),
      .ev              (ev.wdog)
   );

   // Log outputs lag the event pulses by one edge
   monitor_error_log u_log (
      .clk         (clk),
      .arst_n      (arst_n),
      .clear       (clear),
      .ev          (ev.log),
      .err_sticky  (err_sticky),
      .err_count   (err_count),
      .first_src   (first_src),
      .first_rd    (first_rd),
      .first_valid (first_valid),
      .alarm       (alarm)
   );

endmodule

// File: verilog/exu_mon_pkg.sv
// Shared constants and types for the execution unit health monitor
// Every monitor block takes what it needs from here by a wildcard import
package exu_mon_pkg;

   // A register file write word is 64 data bits and one parity bit per byte
   localparam int IRF_WORD_W = 72;
   localparam int IRF_BYTES  = 8;
   localparam int REG_ADDR_W = 5;

   // A request may stay high this many cycles plus one before it counts as stalled
   localparam int STALL_LIMIT = 5;
   // Wide enough to hold STALL_LIMIT+1, where the run counters saturate
   localparam int STALL_CNT_W = 3;

   // The event count saturates at its all-ones value
   localparam int ERR_COUNT_W = 8;

   // Error sources double as sticky flag indices and first_src codes
   localparam int         NUM_SRC     = 3;
   localparam logic [1:0] SRC_WRITE   = 2'd0;
   localparam logic [1:0] SRC_RESTORE = 2'd1;
   localparam logic [1:0] SRC_DIV     = 2'd2;

   // Flat view with the whole data word on top and check bits below it
   typedef struct packed {
      logic [IRF_BYTES*8-1:0] data;
      logic [IRF_BYTES-1:0]   check;
   } irf_flat_t;

   // Lane view of the same bits, where par[i] covers lane[i]
   typedef struct packed {
      logic [IRF_BYTES-1:0][7:0] lane;
      logic [IRF_BYTES-1:0]      par;
   } irf_lanes_t;

   typedef union packed {
      irf_flat_t  flat;
      irf_lanes_t lanes;
   } irf_word_u;

endpackage

// File: verilog/irf_write_checker.sv
// Byte parity check on both register file write ports
// Raises one registered error pulse per cycle in which an enabled port writes a bad word
`timescale 1ns/1ns

module irf_write_checker (
   input  logic                               clk,
   input  logic                               arst_n,
   input  logic                               enable,
   input  logic                               wen1,
   input  logic                               wen2,
   input  exu_mon_pkg::irf_word_u             data1,
   input  exu_mon_pkg::irf_word_u             data2,
   input  logic [exu_mon_pkg::REG_ADDR_W-1:0] rd,
   mon_event_if.wchk                          ev
);
   import exu_mon_pkg::*;

   // Per-lane mismatch of each port, already gated by its write enable
   logic [IRF_BYTES-1:0] bad1;
   logic [IRF_BYTES-1:0] bad2;
   // Which ports carry at least one bad lane
   logic [1:0]           port_hit;
   // Next value of the error strobe
   logic                 err_d;

   // Even parity, so a lane fails when its data XOR its check bit is 1
   function automatic logic [IRF_BYTES-1:0] lane_fail(input irf_word_u w);
      logic [IRF_BYTES-1:0] fail;
      for (int i = 0; i < IRF_BYTES; i++) begin
         fail[i] = (^w.lanes.lane[i]) ^ w.lanes.par[i];
      end
      return fail;
   endfunction

   // A port that is not writing cannot be wrong
   assign bad1 = wen1 ? lane_fail(data1) : '0;
   assign bad2 = wen2 ? lane_fail(data2) : '0;

   assign port_hit[0] = |bad1;
   assign port_hit[1] = |bad2;

   // Nothing is reported while the monitor is switched off
   assign err_d = enable & (|port_hit);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ev.wr_err       <= 1'b0;
         ev.wr_err_port  <= 2'b00;
         ev.wr_err_rd    <= '0;
         ev.wr_err_lanes <= '0;
      end else begin
         ev.wr_err       <= err_d;
         ev.wr_err_port  <= enable ? port_hit : 2'b00;
         // The register number only means something while wr_err is high
         ev.wr_err_rd    <= rd;
         // Both ports share one register number, so the lane masks are simply merged
         ev.wr_err_lanes <= enable ? (bad1 | bad2) : '0;
      end
   end

endmodule

// File: verilog/mon_event_if.sv
// Event bundle between the monitor front ends and the error log
// The checker and the watchdog each drive their own group, the log reads both
`timescale 1ns/1ns

interface mon_event_if;
   import exu_mon_pkg::*;

   // Write checker group, one pulse per cycle with a parity mismatch
   logic                  wr_err;
   logic [REG_ADDR_W-1:0] wr_err_rd;
   // Bit 0 flags port 1 and bit 1 flags port 2
   logic [1:0]            wr_err_port;
   // Failing lanes of both ports ORed together, kept for debug probing
   logic [IRF_BYTES-1:0]  wr_err_lanes;

   // Watchdog group, one pulse per cycle while a request is stalled
   logic                  restore_stall;
   logic                  div_stall;

   modport wchk (
      output wr_err, wr_err_rd, wr_err_port, wr_err_lanes
   );

   modport wdog (
      output restore_stall, div_stall
   );

   // The log sees everything even though it only folds a subset of it
   modport log (
      input wr_err, wr_err_rd, wr_err_port, wr_err_lanes,
      input restore_stall, div_stall
   );

endinterface

// File: verilog/monitor_error_log.sv
// Error log of the health monitor
// Folds the event pulses into sticky flags, a saturating count and a first-error record
`timescale 1ns/1ns

module monitor_error_log (
   input  logic                                clk,
   input  logic                                arst_n,
   input  logic                                clear,
   mon_event_if.log                            ev,
   output logic [exu_mon_pkg::NUM_SRC-1:0]     err_sticky,
   output logic [exu_mon_pkg::ERR_COUNT_W-1:0] err_count,
   output logic [1:0]                          first_src,
   output logic [exu_mon_pkg::REG_ADDR_W-1:0]  first_rd,
   output logic                                first_valid,
   output logic                                alarm
);
   import exu_mon_pkg::*;

   // Events of this cycle, one bit per source
   logic [NUM_SRC-1:0] ev_vec;
   // At least one source fired this cycle
   logic               any_ev;
   // Source that would be recorded as the first error this cycle
   logic [1:0]         pick_src;
   logic [REG_ADDR_W-1:0] pick_rd;

   assign ev_vec[SRC_WRITE]   = ev.wr_err;
   assign ev_vec[SRC_RESTORE] = ev.restore_stall;
   assign ev_vec[SRC_DIV]     = ev.div_stall;

   assign any_ev = |ev_vec;

   // Write beats restore beats divide when several fire together
   always_comb begin
      pick_src = SRC_DIV;
      pick_rd  = '0;
      if (ev.wr_err) begin
         pick_src = SRC_WRITE;
         // Only a write error has a meaningful register number
         pick_rd  = ev.wr_err_rd;
      end else if (ev.restore_stall) begin
         pick_src = SRC_RESTORE;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         err_sticky  <= '0;
         err_count   <= '0;
         first_src   <= 2'b00;
         first_rd    <= '0;
         first_valid <= 1'b0;
      end else if (clear) begin
         // Clear wins, so whatever arrives in this cycle is lost
         err_sticky  <= '0;
         err_count   <= '0;
         first_src   <= 2'b00;
         first_rd    <= '0;
         first_valid <= 1'b0;
      end else begin
         err_sticky <= err_sticky | ev_vec;

         // One count per event cycle, however many sources fired in it
         if (any_ev && (err_count != '1)) begin
            err_count <= err_count + 1'b1;
         end

         // The record freezes on the first event and stays until clear
         if (any_ev && !first_valid) begin
            first_valid <= 1'b1;
            first_src   <= pick_src;
            first_rd    <= pick_rd;
         end
      end
   end

   // Alarm follows the flags directly
   assign alarm = |err_sticky;

endmodule

// File: verilog/req_stall_watchdog.sv
// Watchdog on the restore request and the divide write-back request
// Each request gets its own run counter; a stall pulse repeats while the run is too long
`timescale 1ns/1ns

module req_stall_watchdog (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      enable,
   input  logic      restore_request,
   input  logic      div_wb_req,
   mon_event_if.wdog ev
);
   import exu_mon_pkg::*;

   // Index 0 is the restore request, index 1 the divide write-back request
   logic [1:0] req;
   logic [1:0] stall_q;

   assign req = {div_wb_req, restore_request};

   for (genvar g = 0; g < 2; g++) begin : g_req
      // Consecutive high samples so far, parked at STALL_LIMIT+1
      logic [STALL_CNT_W-1:0] run_cnt;
      logic                   stall;

      always_ff @(posedge clk or negedge arst_n) begin
         if (!arst_n) begin
            run_cnt <= '0;
            stall   <= 1'b0;
         end else if (!enable || !req[g]) begin
            // Any gap in the run, or the monitor going off, starts over
            run_cnt <= '0;
            stall   <= 1'b0;
         end else begin
            // The count seen here is the one before this sample, so pulses start at sample 7
            stall <= (run_cnt == STALL_CNT_W'(STALL_LIMIT + 1));
            if (run_cnt != STALL_CNT_W'(STALL_LIMIT + 1)) begin
               run_cnt <= run_cnt + 1'b1;
            end
         end
      end

      assign stall_q[g] = stall;
   end

   assign ev.restore_stall = stall_q[0];
   assign ev.div_stall     = stall_q[1];

endmodule
